//--- logic/exchange_pkg.sv
`default_nettype none

package exchange_pkg;

    // label source for one slot once the round has been applied
    // NOP leaves the table alone outside the opt_run window
    typedef enum logic [1:0] {
        NOP,
        SELF,
        PREV,
        FOLW
    } exchange_cmd_t;

    // even rounds pair (0,1),(2,3) and odd rounds pair (1,2),(3,4)
    typedef enum logic {
        PHASE_EVEN,
        PHASE_ODD
    } phase_t;

    // number of bits needed to hold a label for count replicas
    function automatic int label_width(input int count);
        int width;
        width = 1;
        while ((1 << width) < count) begin
            width = width + 1;
        end
        return width;
    endfunction

endpackage

`default_nettype wire

//--- logic/fixed_pkg.sv
`default_nettype none

package fixed_pkg;

    // replica energies are signed values of this width
    localparam int energy_w = 24;

    // one extra bit so a difference of two energies cannot overflow
    localparam int delta_w = energy_w + 1;

    // width of the random draw and of the acceptance bound
    localparam int rand_w = 16;

    // number of halving steps, also the value where k saturates
    localparam int exp_steps = 16;

    // Galois feedback mask for the per-replica random source
    localparam logic [rand_w-1:0] lfsr_taps = 16'hB400;

endpackage

`default_nettype wire

//--- logic/exchange_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module exchange_sequencer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    output logic                  busy,
    output logic                  done,
    output logic                  exp_init,
    output logic                  exp_run,
    output logic                  exp_fin,
    output logic                  opt_run,
    output exchange_pkg::phase_t  phase
);
    import exchange_pkg::*;

    // cnt holds n during the cycle that ends at edge n of the round
    localparam logic [4:0] cnt_init = 5'd1;
    localparam logic [4:0] cnt_run_first = 5'd2;
    localparam logic [4:0] cnt_run_last = 5'd17;
    localparam logic [4:0] cnt_fin = 5'd18;
    localparam logic [4:0] cnt_opt = 5'd19;
    localparam logic [4:0] cnt_done = 5'd20;

    logic [4:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == 5'd0 || cnt == cnt_done) begin
            // a new round may start on the same edge that ends the previous one
            cnt <= start ? cnt_init : 5'd0;
        end else begin
            cnt <= cnt + 5'd1;
        end
    end

    assign exp_init = (cnt == cnt_init);
    assign exp_run = (cnt >= cnt_run_first) && (cnt <= cnt_run_last);
    assign exp_fin = (cnt == cnt_fin);
    assign opt_run = (cnt == cnt_opt);
    assign done = (cnt == cnt_done);
    assign busy = (cnt != 5'd0) && (cnt != cnt_done);

    // the phase stays visible through the done cycle and flips after it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PHASE_EVEN;
        end else if (done) begin
            phase <= (phase == PHASE_EVEN) ? PHASE_ODD : PHASE_EVEN;
        end
    end

endmodule

`default_nettype wire

//--- logic/accept_bound.sv
`timescale 1ns/100ps
`default_nettype none

module accept_bound #(
    parameter int beta_shift = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic signed [fixed_pkg::delta_w-1:0] delta,
    input  logic                                 init,
    input  logic                                 run,
    output logic        [fixed_pkg::rand_w-1:0]  bound
);
    import fixed_pkg::*;

    localparam int k_w = $clog2(exp_steps + 1);

    logic signed [delta_w-1:0] scaled;
    logic        [k_w-1:0]     k_d;
    logic        [k_w-1:0]     k_q;
    logic        [k_w-1:0]     step;

    assign scaled = delta >>> beta_shift;

    // the step count k is zero for downhill moves and capped at exp_steps
    always_comb begin
        if (delta <= 0) begin
            k_d = '0;
        end else if (scaled >= exp_steps) begin
            k_d = k_w'(exp_steps);
        end else begin
            k_d = scaled[k_w-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            k_q <= '0;
            step <= '0;
        end else if (init) begin
            k_q <= k_d;
            step <= '0;
        end else if (run) begin
            step <= step + 1'b1;
        end
    end

    // all ones halved k times approximates 2^-k of the full range
    always_ff @(posedge clk) begin
        if (init) begin
            bound <= '1;
        end else if (run && (step < k_q)) begin
            bound <= bound >> 1;
        end
    end

endmodule

`default_nettype wire

//--- logic/replica.sv
`timescale 1ns/100ps
`default_nettype none

module replica #(
    parameter int id = 0,
    parameter int replica_num = 4,
    parameter int beta_shift = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  exp_init,
    input  logic                                  exp_run,
    input  logic                                  exp_fin,
    input  logic                                  opt_run,
    input  exchange_pkg::phase_t                  phase,
    input  logic signed [fixed_pkg::energy_w-1:0] self_energy,
    input  logic signed [fixed_pkg::energy_w-1:0] prev_energy,
    input  logic signed [fixed_pkg::energy_w-1:0] folw_energy,
    input  logic                                  prev_test,
    input  logic                                  folw_test,
    output logic                                  out_test,
    output exchange_pkg::exchange_cmd_t           cmd
);
    import exchange_pkg::*;
    import fixed_pkg::*;

    localparam bit is_even = (id % 2) == 0;
    localparam bit has_prev = id > 0;
    localparam bit has_folw = id < replica_num - 1;

    logic                      decider;
    logic signed [delta_w-1:0] delta_d;
    logic signed [delta_w-1:0] delta_q;
    logic        [rand_w-1:0]  lfsr;
    logic        [rand_w-1:0]  bound;
    logic                      test;
    exchange_cmd_t             cmd_d;

    // even ids decide, looking forward in even rounds and back in odd ones
    assign decider = (phase == PHASE_EVEN) ? (is_even && has_folw) : (is_even && has_prev);

    assign delta_d = (phase == PHASE_EVEN) ? (folw_energy - self_energy)
                                           : (self_energy - prev_energy);

    accept_bound #(
        .beta_shift (beta_shift)
    ) bound_i (
        .clk   (clk),
        .rst_n (rst_n),
        .delta (delta_d),
        .init  (exp_init),
        .run   (exp_run),
        .bound (bound)
    );

    always_ff @(posedge clk) begin
        if (exp_init) begin
            delta_q <= delta_d;
        end
    end

    // the draw compared here is the value from before this round's advance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= rand_w'(id + 1);
            test <= 1'b0;
        end else if (exp_fin) begin
            lfsr <= lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
            test <= decider && ((delta_q <= 0) || (lfsr < bound));
        end
    end

    assign out_test = test;

    // partners mirror the decider so the two commands always match up
    always_comb begin
        cmd_d = SELF;
        if (phase == PHASE_EVEN) begin
            if (is_even && has_folw) begin
                cmd_d = test ? FOLW : SELF;
            end else if (!is_even) begin
                cmd_d = prev_test ? PREV : SELF;
            end
        end else begin
            if (is_even && has_prev) begin
                cmd_d = test ? PREV : SELF;
            end else if (!is_even && has_folw) begin
                cmd_d = folw_test ? FOLW : SELF;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= NOP;
        end else begin
            cmd <= opt_run ? cmd_d : NOP;
        end
    end

endmodule

`default_nettype wire

//--- logic/label_swap.sv
`timescale 1ns/100ps
`default_nettype none

module label_swap #(
    parameter int replica_num = 4
) (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  exchange_pkg::exchange_cmd_t [replica_num-1:0]            cmd,
    output logic [replica_num-1:0][exchange_pkg::label_width(replica_num)-1:0] labels
);
    import exchange_pkg::*;

    localparam int lw = label_width(replica_num);

    for (genvar i = 0; i < replica_num; i++) begin : g_slot
        // ends point at themselves since a matched pair never sends them outward
        localparam int prev_i = (i == 0) ? 0 : i - 1;
        localparam int folw_i = (i == replica_num - 1) ? i : i + 1;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                labels[i] <= lw'(i);
            end else begin
                case (cmd[i])
                    PREV:    labels[i] <= labels[prev_i];
                    FOLW:    labels[i] <= labels[folw_i];
                    default: labels[i] <= labels[i];
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/exchange_top.sv
`timescale 1ns/100ps
`default_nettype none

module exchange_top #(
    parameter int replica_num = 4,
    parameter int beta_shift = 4
) (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   start,
    input  logic signed [replica_num-1:0][fixed_pkg::energy_w-1:0] energy,
    output logic                                                   busy,
    output logic                                                   done,
    output exchange_pkg::phase_t                                   phase,
    output exchange_pkg::exchange_cmd_t [replica_num-1:0]          cmd,
    output logic [replica_num-1:0][exchange_pkg::label_width(replica_num)-1:0] labels
);

    logic                   exp_init;
    logic                   exp_run;
    logic                   exp_fin;
    logic                   opt_run;
    logic [replica_num-1:0] test_vec;

    exchange_sequencer sequencer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .busy     (busy),
        .done     (done),
        .exp_init (exp_init),
        .exp_run  (exp_run),
        .exp_fin  (exp_fin),
        .opt_run  (opt_run),
        .phase    (phase)
    );

    for (genvar i = 0; i < replica_num; i++) begin : g_replica
        // the chain ends fall back to their own energy and test
        localparam int prev_i = (i == 0) ? 0 : i - 1;
        localparam int folw_i = (i == replica_num - 1) ? i : i + 1;

        replica #(
            .id          (i),
            .replica_num (replica_num),
            .beta_shift  (beta_shift)
        ) replica_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .exp_init    (exp_init),
            .exp_run     (exp_run),
            .exp_fin     (exp_fin),
            .opt_run     (opt_run),
            .phase       (phase),
            .self_energy (energy[i]),
            .prev_energy (energy[prev_i]),
            .folw_energy (energy[folw_i]),
            .prev_test   (test_vec[prev_i]),
            .folw_test   (test_vec[folw_i]),
            .out_test    (test_vec[i]),
            .cmd         (cmd[i])
        );
    end

    label_swap #(
        .replica_num (replica_num)
    ) label_swap_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd    (cmd),
        .labels (labels)
    );

endmodule

`default_nettype wire

//--- verification/exchange_properties.sv
`timescale 1ns/100ps
`default_nettype none

module exchange_properties #(
    parameter int replica_num = 4
) (
    input logic                                         clk,
    input logic                                         rst_n,
    input logic                                         start,
    input logic                                         busy,
    input logic                                         done,
    input exchange_pkg::exchange_cmd_t [replica_num-1:0] cmd
);
    import exchange_pkg::*;

    // an accepted start shows up as done exactly twenty edges later, and never otherwise
    round_length: assert property (@(posedge clk) disable iff (!rst_n)
        done == $past(start && !busy, 20))
        else $error("done does not follow an accepted start by 20 cycles");

    // busy rises after an accepted start and stays up until the done cycle, where it is low
    busy_window: assert property (@(posedge clk) disable iff (!rst_n)
        busy == (!done && ($past(busy) || $past(start && !busy))))
        else $error("busy does not span the cycles from an accepted start to done");

    // a slot pulling from its follower needs the follower pulling back
    for (genvar i = 0; i < replica_num - 1; i++) begin : g_pair
        pair_match: assert property (@(posedge clk) disable iff (!rst_n)
            (cmd[i] == FOLW) == (cmd[i + 1] == PREV))
            else $error("commands of slots %0d and %0d do not pair up", i, i + 1);
    end

endmodule

bind exchange_top exchange_properties #(
    .replica_num (replica_num)
) properties_i (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done),
    .cmd   (cmd)
);

`default_nettype wire

//--- verification/exchange_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exchange_tb;
    import exchange_pkg::*;
    import fixed_pkg::*;

    localparam int n = 4;
    localparam int shift = 4;
    localparam int lw = label_width(n);
    localparam int rows = 14;
    localparam int timeout = 40;

    typedef logic [n-1:0][lw-1:0] label_vec_t;

    logic                              clk;
    logic                              rst_n;
    logic                              start;
    logic signed [n-1:0][energy_w-1:0] energy;
    logic                              busy;
    logic                              done;
    phase_t                            phase;
    exchange_cmd_t [n-1:0]             cmd;
    label_vec_t                        labels;

    // mode 1 of a row adds a start while busy and mode 2 resets the DUT mid-round
    string row_name[rows];
    int    row_e[rows][n];
    int    row_spread[rows];
    int    row_mode[rows];

    logic [15:0]   lfsr_m[n];
    label_vec_t    labels_m;
    phase_t        phase_m;
    exchange_cmd_t exp_cmd[n];
    int            cur_e[n];
    int            tests = 0;
    int            checks = 0;
    int            fails = 0;
    int            test_fails = 0;

    exchange_top #(
        .replica_num (n),
        .beta_shift  (shift)
    ) dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .energy (energy),
        .busy   (busy),
        .done   (done),
        .phase  (phase),
        .cmd    (cmd),
        .labels (labels)
    );

    always #50 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic set_row(input int idx, input string name, input int e0, input int e1,
                           input int e2, input int e3, input int spread, input int mode);
        row_name[idx] = name;
        row_e[idx] = '{e0, e1, e2, e3};
        row_spread[idx] = spread;
        row_mode[idx] = mode;
    endtask

    task automatic record_fail();
        fails++;
        test_fails++;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (test_fails == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d mismatches", name, test_fails);
        end
        test_fails = 0;
    endtask

    task automatic check_cmd(input string name, input int slot, input exchange_cmd_t expected,
                             input exchange_cmd_t actual);
        checks++;
        if (actual !== expected) begin
            record_fail();
            $display("FAIL %s cmd[%0d]: expected %s, actual %s", name, slot,
                     expected.name(), actual.name());
        end
    endtask

    task automatic check_labels(input string name, input label_vec_t expected,
                                input label_vec_t actual);
        checks++;
        if (actual !== expected) begin
            record_fail();
            $display("FAIL %s labels: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_phase(input string name, input phase_t expected, input phase_t actual);
        checks++;
        if (actual !== expected) begin
            record_fail();
            $display("FAIL %s phase: expected %s, actual %s", name, expected.name(), actual.name());
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            record_fail();
            $display("FAIL %s busy: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            record_fail();
            $display("FAIL %s start-to-done cycles: expected %0d, actual %0d", name, expected,
                     actual);
        end
    endtask

    // one step of a replica's Galois random source with mask B400
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // downhill always swaps, uphill needs a draw below all ones shifted right by k
    function automatic bit accept(input int delta, input logic [15:0] draw);
        int k;
        if (delta <= 0) begin
            return 1'b1;
        end
        k = delta >> shift;
        if (k >= 16) begin
            return 1'b0;
        end
        return draw < (16'hFFFF >> k);
    endfunction

    task automatic model_reset();
        for (int i = 0; i < n; i++) begin
            lfsr_m[i] = 16'(i + 1);
            labels_m[i] = lw'(i);
        end
        phase_m = PHASE_EVEN;
    endtask

    // even rounds decide at the lower slot of each pair, odd rounds at the upper one
    task automatic model_round();
        label_vec_t next;
        next = labels_m;
        for (int i = 0; i < n; i++) begin
            exp_cmd[i] = SELF;
        end
        for (int d = 0; d < n; d += 2) begin
            if (phase_m == PHASE_EVEN && d + 1 < n) begin
                if (accept(cur_e[d + 1] - cur_e[d], lfsr_m[d])) begin
                    exp_cmd[d] = FOLW;
                    exp_cmd[d + 1] = PREV;
                    next[d] = labels_m[d + 1];
                    next[d + 1] = labels_m[d];
                end
            end else if (phase_m == PHASE_ODD && d > 0) begin
                if (accept(cur_e[d] - cur_e[d - 1], lfsr_m[d])) begin
                    exp_cmd[d] = PREV;
                    exp_cmd[d - 1] = FOLW;
                    next[d] = labels_m[d - 1];
                    next[d - 1] = labels_m[d];
                end
            end
        end
        for (int i = 0; i < n; i++) begin
            lfsr_m[i] = lfsr_next(lfsr_m[i]);
        end
        labels_m = next;
    endtask

    task automatic check_reset_state(input string name);
        check_labels(name, labels_m, labels);
        check_busy(name, 1'b0, busy);
        for (int i = 0; i < n; i++) begin
            check_cmd(name, i, NOP, cmd[i]);
        end
        check_phase(name, PHASE_EVEN, phase);
        finish_test(name);
    endtask

    task automatic run_round(input int row);
        int cycles;
        string name;
        name = row_name[row];
        for (int i = 0; i < n; i++) begin
            cur_e[i] = row_e[row][i];
            if (row_spread[row] > 0) begin
                cur_e[i] = cur_e[i] + int'($urandom % row_spread[row]);
            end
            energy[i] = energy_w'(cur_e[i]);
        end
        start = 1'b1;
        tick();
        start = 1'b0;
        cycles = 1;
        if (row_mode[row] == 2) begin
            repeat (7) tick();
            rst_n = 1'b0;
            repeat (16) tick();
            rst_n = 1'b1;
            model_reset();
            check_reset_state(name);
            return;
        end
        while (!done && cycles < timeout) begin
            start = (row_mode[row] == 1) && (cycles == 6);
            tick();
            cycles++;
        end
        start = 1'b0;
        if (!done) begin
            record_fail();
            $display("ERROR %s: done never arrived within %0d cycles of start", name, timeout);
            finish_test(name);
            return;
        end
        model_round();
        check_cycles(name, 20, cycles);
        check_phase(name, phase_m, phase);
        for (int i = 0; i < n; i++) begin
            check_cmd(name, i, exp_cmd[i], cmd[i]);
        end
        phase_m = (phase_m == PHASE_EVEN) ? PHASE_ODD : PHASE_EVEN;
        // labels move on the edge that ends done
        tick();
        check_labels(name, labels_m, labels);
        check_busy(name, 1'b0, busy);
        finish_test(name);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        energy = '0;
        void'($urandom(32'hb768_c02e));
        set_row(0, "downhill_even", 4000, 3000, 2000, 1000, 0, 0);
        set_row(1, "downhill_odd", 4000, 3000, 2000, 1000, 0, 0);
        set_row(2, "uphill_sat_even", 0, 1000000, 2000000, 3000000, 0, 0);
        set_row(3, "uphill_sat_odd", 0, 1000000, 2000000, 3000000, 0, 0);
        set_row(4, "mid_k2_even", 100, 140, -500, -460, 0, 0);
        set_row(5, "mid_k5_odd", 0, -200, -120, 0, 0, 0);
        set_row(6, "mid_rand_a", -3000, -2900, -2800, -2700, 200, 0);
        set_row(7, "mid_rand_b", -3000, -2900, -2800, -2700, 200, 0);
        set_row(8, "mid_rand_c", 5000, 5100, 5050, 5200, 256, 0);
        set_row(9, "busy_restart", 0, 64, 128, 192, 0, 1);
        set_row(10, "near_sat", 0, 240, 480, 720, 64, 0);
        // this round runs in the odd phase, so the reset has to bring the phase back
        set_row(11, "reset_mid_round", 0, 10, 20, 30, 0, 2);
        set_row(12, "after_reset", 8, 4, 2, 1, 0, 0);
        set_row(13, "mid_rand_d", -100, 0, 100, 200, 300, 0);
        model_reset();
        repeat (16) tick();
        rst_n = 1'b1;
        check_reset_state("reset_state");
        for (int r = 0; r < rows; r++) begin
            run_round(r);
        end
        $display("tests: %0d, checks: %0d, failures: %0d", tests, checks, fails);
        if (fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/exchange_pkg.sv
logic/fixed_pkg.sv
logic/exchange_sequencer.sv
logic/accept_bound.sv
logic/replica.sv
logic/label_swap.sv
logic/exchange_top.sv
verification/exchange_properties.sv
verification/exchange_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module exchange_tb -f sources.f

sim:
	verilator --binary --timing --assert --top-module exchange_tb -Mdir obj_dir -f sources.f
	./obj_dir/Vexchange_tb | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
